//--- Makefile
# Verilator build and run for the execution core testbench

VERILATOR ?= verilator
TOP       ?= tb_ExecCore
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Result: PASSED
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BIN) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+hw
hw/isa_pkg.sv
hw/exec_pkg.sv
hw/InstrDecode.sv
hw/RegFile.sv
hw/AluExecute.sv
hw/ResultStage.sv
hw/ExecCore.sv
tb/CoreChecker.sv
tb/tb_ExecCore.sv

//--- hw/AluExecute.sv
// Execute stage ALU
// Computes the result and signed overflow from registered operands
`include "core_params.svh"

module AluExecute import exec_pkg::*; (
	input  logic                       exValid,
	input  aluOpT                      exAluOp,
	input  logic [`DATA_WIDTH-1:0]     exOperandA,
	input  logic [`DATA_WIDTH-1:0]     exOperandB,
	input  logic [`IMM_WIDTH-1:0]      exImm,
	input  logic [4:0]                 exShift,
	input  logic [`REG_ADDR_WIDTH-1:0] exWriteAddr,
	input  logic                       exFlagEn,
	input  logic                       exIllegal,
	output logic                       resValid,
	output logic [`REG_ADDR_WIDTH-1:0] resAddr,
	output logic [`DATA_WIDTH-1:0]     resData,
	output logic                       resOverflow,
	output logic                       resFlagEn,
	output logic                       resIllegal
);

	localparam int Msb = `DATA_WIDTH - 1;

	logic [`DATA_WIDTH-1:0] sum;
	logic [`DATA_WIDTH-1:0] diff;

	assign sum  = exOperandA + exOperandB;
	assign diff = exOperandA - exOperandB;

	always_comb begin
		resData     = '0;
		resOverflow = 1'b0;
		case (exAluOp)
			AluAdd: begin
				resData     = sum;
				// Same-sign inputs with a sign flip
				resOverflow = (exOperandA[Msb] == exOperandB[Msb]) &&
					(sum[Msb] != exOperandA[Msb]);
			end
			AluSub: begin
				resData     = diff;
				resOverflow = (exOperandA[Msb] != exOperandB[Msb]) &&
					(diff[Msb] != exOperandA[Msb]);
			end
			// Upper half from the immediate, lower half kept
			AluLhw: resData = {exImm, exOperandA[`IMM_WIDTH-1:0]};
			AluLlw: resData = {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, exImm};
			AluAnd: resData = exOperandA & exOperandB;
			AluOr:  resData = exOperandA | exOperandB;
			AluXor: resData = exOperandA ^ exOperandB;
			AluNot: resData = ~exOperandA;
			AluSll: resData = exOperandA << exShift;
			AluSrl: resData = exOperandA >> exShift;
			AluSra: resData = $signed(exOperandA) >>> exShift;
			default: resData = '0;
		endcase
	end

	assign resValid   = exValid && !exIllegal;
	assign resAddr    = exWriteAddr;
	assign resFlagEn  = exFlagEn;
	assign resIllegal = exIllegal;

endmodule

//--- hw/ExecCore.sv
// Execution core top level
// Decode, register file, ALU and result stage
`include "core_params.svh"

module ExecCore import exec_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       instrValid,
	input  logic [31:0]                instruction,
	output logic                       retireValid,
	output logic [`REG_ADDR_WIDTH-1:0] retireAddr,
	output logic [`DATA_WIDTH-1:0]     retireData,
	output logic                       zeroFlag,
	output logic                       negativeFlag,
	output logic                       overflowFlag,
	output logic                       illegalOp,
	output logic                       halted
);

	logic [`REG_ADDR_WIDTH-1:0] rdAddr0;
	logic [`REG_ADDR_WIDTH-1:0] rdAddr1;
	logic [`DATA_WIDTH-1:0]     rdData0;
	logic [`DATA_WIDTH-1:0]     rdData1;
	logic                       exValid;
	aluOpT                      exAluOp;
	logic [`DATA_WIDTH-1:0]     exOperandA;
	logic [`DATA_WIDTH-1:0]     exOperandB;
	logic [`IMM_WIDTH-1:0]      exImm;
	logic [4:0]                 exShift;
	logic [`REG_ADDR_WIDTH-1:0] exWriteAddr;
	logic                       exFlagEn;
	logic                       exIllegal;
	logic                       resValid;
	logic [`REG_ADDR_WIDTH-1:0] resAddr;
	logic [`DATA_WIDTH-1:0]     resData;
	logic                       resOverflow;
	logic                       resFlagEn;
	logic                       resIllegal;
	logic                       wrEn;
	logic [`REG_ADDR_WIDTH-1:0] wrAddr;
	logic [`DATA_WIDTH-1:0]     wrData;

	InstrDecode decode (.*);

	RegFile regFile (.*);

	AluExecute alu (.*);

	ResultStage result (.*);

endmodule

//--- hw/InstrDecode.sv
// Instruction decoder
// Classifies opcodes, reads operands and loads the execute stage
`include "core_params.svh"

module InstrDecode import isa_pkg::*, exec_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       instrValid,
	input  logic [31:0]                instruction,
	output logic [`REG_ADDR_WIDTH-1:0] rdAddr0,
	output logic [`REG_ADDR_WIDTH-1:0] rdAddr1,
	input  logic [`DATA_WIDTH-1:0]     rdData0,
	input  logic [`DATA_WIDTH-1:0]     rdData1,
	output logic                       exValid,
	output aluOpT                      exAluOp,
	output logic [`DATA_WIDTH-1:0]     exOperandA,
	output logic [`DATA_WIDTH-1:0]     exOperandB,
	output logic [`IMM_WIDTH-1:0]      exImm,
	output logic [4:0]                 exShift,
	output logic [`REG_ADDR_WIDTH-1:0] exWriteAddr,
	output logic                       exFlagEn,
	output logic                       exIllegal,
	output logic                       halted
);

	opcodeT                     opcode;
	decodeStateT                state;
	logic [`REG_ADDR_WIDTH-1:0] rd;
	logic [`REG_ADDR_WIDTH-1:0] rn1;
	logic [`REG_ADDR_WIDTH-1:0] rn2;
	logic                       accept;
	logic                       isSupported;
	logic                       isHalt;
	logic                       setsFlags;

	assign opcode = opcodeT'(instruction[OpcodeMsb:OpcodeLsb]);
	assign rd     = instruction[RdMsb:RdLsb];
	assign rn1    = instruction[Rn1Msb:Rn1Lsb];
	assign rn2    = instruction[Rn2Msb:Rn2Lsb];

	assign isSupported = opcode inside {OpAdd, OpSub, OpLhw, OpLlw, OpAnd, OpOr,
		OpXor, OpNot, OpSll, OpSrl, OpSra};
	assign isHalt    = (opcode == OpHalt);
	assign setsFlags = isSupported && !(opcode inside {OpLhw, OpLlw});
	assign accept    = instrValid && (state == Running);
	assign halted    = (state == Halted);

	// Read port selection follows the reference decoder
	always_comb begin
		case (opcode)
			OpLhw, OpEnqd: rdAddr0 = rd;
			OpCall, OpRet: rdAddr0 = `REG_ADDR_WIDTH'(1);
			default:       rdAddr0 = rn1;
		endcase
		case (opcode)
			OpStore: rdAddr1 = rd;
			OpLoad:  rdAddr1 = rn1;
			OpRet:   rdAddr1 = '0;
			default: rdAddr1 = rn2;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= Running;
			exValid   <= 1'b0;
			exIllegal <= 1'b0;
			exFlagEn  <= 1'b0;
		end else begin
			exValid   <= accept && isSupported;
			exIllegal <= accept && !isSupported && !isHalt;
			exFlagEn  <= accept && setsFlags;
			if (accept && isHalt)
				state <= Halted;
		end
	end

	// Operand and payload capture
	always_ff @(posedge clk) begin
		if (accept) begin
			exAluOp     <= aluOpT'(opcode[3:0]);
			exOperandA  <= rdData0;
			exOperandB  <= rdData1;
			exImm       <= instruction[`IMM_WIDTH-1:0];
			exShift     <= instruction[ShamtMsb:ShamtLsb];
			exWriteAddr <= rd;
		end
	end

	haltBlocksIssue: assert property (@(posedge clk) disable iff (rst)
		state == Halted |-> !exValid);

endmodule

//--- hw/RegFile.sv
// Register file with two read ports and one write port
// Reads bypass the write port when addresses match
`include "core_params.svh"

module RegFile (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`REG_ADDR_WIDTH-1:0] rdAddr0,
	input  logic [`REG_ADDR_WIDTH-1:0] rdAddr1,
	output logic [`DATA_WIDTH-1:0]     rdData0,
	output logic [`DATA_WIDTH-1:0]     rdData1,
	input  logic                       wrEn,
	input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
	input  logic [`DATA_WIDTH-1:0]     wrData
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Write-through so a back-to-back dependent instruction sees the new value
	assign rdData0 = (wrEn && wrAddr == rdAddr0) ? wrData : regs[rdAddr0];
	assign rdData1 = (wrEn && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];

	wrAddrKnown: assert property (@(posedge clk) disable iff (rst)
		wrEn |-> !$isunknown(wrAddr));

endmodule

//--- hw/ResultStage.sv
// Result stage
// Writes back, keeps the flags and reports retired instructions
`include "core_params.svh"

module ResultStage (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       resValid,
	input  logic [`REG_ADDR_WIDTH-1:0] resAddr,
	input  logic [`DATA_WIDTH-1:0]     resData,
	input  logic                       resOverflow,
	input  logic                       resFlagEn,
	input  logic                       resIllegal,
	output logic                       wrEn,
	output logic [`REG_ADDR_WIDTH-1:0] wrAddr,
	output logic [`DATA_WIDTH-1:0]     wrData,
	output logic                       retireValid,
	output logic [`REG_ADDR_WIDTH-1:0] retireAddr,
	output logic [`DATA_WIDTH-1:0]     retireData,
	output logic                       zeroFlag,
	output logic                       negativeFlag,
	output logic                       overflowFlag,
	output logic                       illegalOp
);

	assign wrEn   = resValid;
	assign wrAddr = resAddr;
	assign wrData = resData;

	always_ff @(posedge clk) begin
		if (rst) begin
			retireValid  <= 1'b0;
			illegalOp    <= 1'b0;
			zeroFlag     <= 1'b0;
			negativeFlag <= 1'b0;
			overflowFlag <= 1'b0;
		end else begin
			retireValid <= resValid;
			illegalOp   <= resIllegal;
			if (resValid && resFlagEn) begin
				zeroFlag     <= (resData == '0);
				negativeFlag <= resData[`DATA_WIDTH-1];
				overflowFlag <= resOverflow;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resValid) begin
			retireAddr <= resAddr;
			retireData <= resData;
		end
	end

	retireOrIllegal: assert property (@(posedge clk) disable iff (rst)
		!(retireValid && illegalOp));

endmodule

//--- hw/core_params.svh
// Core width parameters
// Shared sizes for the register file, datapath and immediate field
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and result width
`define DATA_WIDTH 32

// Register file size
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// LHW/LLW immediate, instruction bits 15 to 0
`define IMM_WIDTH 16

`endif

//--- hw/exec_pkg.sv
// Execution package
// ALU operation codes and decoder state
package exec_pkg;

	// Matches the low four opcode bits
	typedef enum logic [3:0] {
		AluAdd = 4'b0000,
		AluSub = 4'b0001,
		AluLhw = 4'b0010,
		AluLlw = 4'b0011,
		AluAnd = 4'b0100,
		AluOr  = 4'b0101,
		AluXor = 4'b0110,
		AluNot = 4'b0111,
		AluSll = 4'b1000,
		AluSrl = 4'b1001,
		AluSra = 4'b1010
	} aluOpT;

	typedef enum logic {
		Running,
		Halted
	} decodeStateT;

endpackage

//--- hw/isa_pkg.sv
// ISA package
// Opcode encoding and instruction field positions
package isa_pkg;

	typedef enum logic [5:0] {
		OpAdd    = 6'b00_0000,
		OpSub    = 6'b00_0001,
		OpLhw    = 6'b00_0010,
		OpLlw    = 6'b00_0011,
		OpAnd    = 6'b00_0100,
		OpOr     = 6'b00_0101,
		OpXor    = 6'b00_0110,
		OpNot    = 6'b00_0111,
		OpSll    = 6'b00_1000,
		OpSrl    = 6'b00_1001,
		OpSra    = 6'b00_1010,
		OpFlush  = 6'b00_1100,
		OpBranch = 6'b01_0000,
		OpCall   = 6'b01_0001,
		OpRet    = 6'b01_0010,
		OpLoad   = 6'b01_0100,
		OpStore  = 6'b01_0101,
		OpMult   = 6'b01_0110,
		OpDiv    = 6'b01_0111,
		OpFadd   = 6'b01_1000,
		OpFsub   = 6'b01_1001,
		OpFmult  = 6'b01_1010,
		OpFdiv   = 6'b01_1011,
		OpFtoi   = 6'b01_1100,
		OpItof   = 6'b01_1101,
		OpSqrt   = 6'b01_1110,
		OpHalt   = 6'b01_1111,
		OpEnqc   = 6'b10_0000,
		OpEnqd   = 6'b10_0100,
		OpDeqd   = 6'b10_0101
	} opcodeT;

	// Field bit ranges
	localparam int OpcodeMsb = 31;
	localparam int OpcodeLsb = 26;
	localparam int RdMsb     = 25;
	localparam int RdLsb     = 21;
	localparam int Rn1Msb    = 20;
	localparam int Rn1Lsb    = 16;
	localparam int Rn2Msb    = 15;
	localparam int Rn2Lsb    = 11;
	localparam int ShamtMsb  = 4;
	localparam int ShamtLsb  = 0;

endpackage

//--- tb/CoreChecker.sv
// Retire checker for the execution core
// Shadow register file and flags, compared against the retire ports
`include "core_params.svh"

module CoreChecker import isa_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       instrValid,
	input  logic [31:0]                instruction,
	input  logic                       retireValid,
	input  logic [`REG_ADDR_WIDTH-1:0] retireAddr,
	input  logic [`DATA_WIDTH-1:0]     retireData,
	input  logic                       zeroFlag,
	input  logic                       negativeFlag,
	input  logic                       overflowFlag,
	input  logic                       illegalOp,
	input  logic                       halted,
	input  logic                       stimDone,
	output logic                       done,
	output int                         errorCount,
	output int                         checkCount
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic                       valid;
		logic                       illegal;
		logic [`REG_ADDR_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0]     data;
		logic                       zero;
		logic                       negative;
		logic                       overflow;
	} expectT;

	logic [`DATA_WIDTH-1:0] shadow [`REG_COUNT];
	logic                   shZero;
	logic                   shNeg;
	logic                   shOvf;
	logic                   shHalted;
	expectT                 stage1;
	expectT                 stage2;
	int                     drain;

	// Expected write data, overflow and whether the flags move
	function automatic void predict(input logic [31:0] instr, input logic [31:0] a,
		input logic [31:0] b, output logic [31:0] data, output logic ovf,
		output logic flagEn);
		logic [32:0] wide;
		logic [4:0]  sh;
		sh = instr[ShamtMsb:ShamtLsb];
		data = '0;
		ovf = 1'b0;
		flagEn = 1'b1;
		case (opcodeT'(instr[OpcodeMsb:OpcodeLsb]))
			OpAdd: begin
				wide = {a[31], a} + {b[31], b};
				data = wide[31:0];
				ovf = wide[32] ^ wide[31];
			end
			OpSub: begin
				wide = {a[31], a} - {b[31], b};
				data = wide[31:0];
				ovf = wide[32] ^ wide[31];
			end
			OpLhw: begin
				data = {instr[15:0], a[15:0]};
				flagEn = 1'b0;
			end
			OpLlw: begin
				data = {16'h0000, instr[15:0]};
				flagEn = 1'b0;
			end
			OpAnd: data = a & b;
			OpOr:  data = a | b;
			OpXor: data = a ^ b;
			OpNot: data = ~a;
			OpSll: data = a << sh;
			OpSrl: data = a >> sh;
			// Sign fill for the vacated upper bits
			OpSra: data = (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
			default: flagEn = 1'b0;
		endcase
	endfunction

	function automatic expectT accept(input logic [31:0] instr);
		expectT                 e;
		opcodeT                 op;
		logic [`DATA_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] data;
		logic                   ovf;
		logic                   flagEn;
		op = opcodeT'(instr[OpcodeMsb:OpcodeLsb]);
		a = (op == OpLhw) ? shadow[instr[RdMsb:RdLsb]] : shadow[instr[Rn1Msb:Rn1Lsb]];
		predict(instr, a, shadow[instr[Rn2Msb:Rn2Lsb]], data, ovf, flagEn);
		e = '0;
		if (op inside {OpAdd, OpSub, OpLhw, OpLlw, OpAnd, OpOr, OpXor, OpNot, OpSll,
			OpSrl, OpSra}) begin
			e.valid = 1'b1;
			e.addr = instr[RdMsb:RdLsb];
			e.data = data;
			shadow[e.addr] = data;
			if (flagEn) begin
				shZero = (data == '0);
				shNeg = data[31];
				shOvf = ovf;
			end
		end else if (op == OpHalt) begin
			shHalted = 1'b1;
		end else begin
			e.illegal = 1'b1;
		end
		return e;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual,
				$time);
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++)
				shadow[i] = '0;
			shZero = 1'b0;
			shNeg = 1'b0;
			shOvf = 1'b0;
			shHalted = 1'b0;
			stage1 = '0;
			stage2 = '0;
			drain = 0;
			errorCount = 0;
			checkCount = 0;
			done <= 1'b0;
		end else begin
			// Ports now show the instruction accepted two edges back
			compare("retireValid", 32'(stage2.valid), 32'(retireValid));
			if (stage2.valid) begin
				compare("retireAddr", 32'(stage2.addr), 32'(retireAddr));
				compare("retireData", stage2.data, retireData);
			end
			compare("illegalOp", 32'(stage2.illegal), 32'(illegalOp));
			compare("zeroFlag", 32'(stage2.zero), 32'(zeroFlag));
			compare("negativeFlag", 32'(stage2.negative), 32'(negativeFlag));
			compare("overflowFlag", 32'(stage2.overflow), 32'(overflowFlag));
			compare("halted", 32'(shHalted), 32'(halted));
			stage2 = stage1;
			stage1 = (instrValid && !shHalted) ? accept(instruction) : '0;
			stage1.zero = shZero;
			stage1.negative = shNeg;
			stage1.overflow = shOvf;
			if (stimDone)
				drain++;
			done <= (drain > 3);
		end
	end

endmodule

//--- tb/tb_ExecCore.sv
// Testbench for the execution core
// Random instruction streams into the DUT, checked by the retire checker
`include "core_params.svh"

module tb_ExecCore import isa_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic                       clk;
	logic                       rst;
	logic                       instrValid;
	logic [31:0]                instruction;
	logic                       retireValid;
	logic [`REG_ADDR_WIDTH-1:0] retireAddr;
	logic [`DATA_WIDTH-1:0]     retireData;
	logic                       zeroFlag;
	logic                       negativeFlag;
	logic                       overflowFlag;
	logic                       illegalOp;
	logic                       halted;
	logic                       stimDone;
	logic                       done;
	int                         errorCount;
	int                         checkCount;
	logic [31:0]                rngState;

	opcodeT goodOps[11] = '{OpAdd, OpSub, OpLhw, OpLlw, OpAnd, OpOr, OpXor, OpNot,
		OpSll, OpSrl, OpSra};
	opcodeT badOps[13] = '{OpFlush, OpBranch, OpCall, OpRet, OpLoad, OpStore, OpMult,
		OpDiv, OpFadd, OpSqrt, OpEnqc, OpEnqd, OpDeqd};

	ExecCore DUT (.*);

	CoreChecker retireCheck (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic issue(input logic [31:0] instr);
		@(posedge clk);
		instrValid <= 1'b1;
		instruction <= instr;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			instrValid <= 1'b0;
		end
	endtask

	// Registers limited to r0..r7 so dependent pairs are frequent
	task automatic issueRandom();
		logic [31:0] r;
		int          idx;
		r = nextRand();
		idx = int'(r[31:28]) % 11;
		issue({goodOps[idx], 2'b00, r[23:21], 2'b00, r[18:16], 2'b00, r[13:0]});
	endtask

	initial begin
		logic [31:0] r;
		int          timeout;
		rst = 1'b1;
		instrValid = 1'b0;
		instruction = '0;
		stimDone = 1'b0;
		rngState = 32'd93;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		// Reads r0 and r1 straight out of reset
		issue({OpAdd, 5'd5, 5'd0, 5'd1, 11'd0});
		idle(2);
		for (int i = 0; i < `REG_COUNT; i++) begin
			r = nextRand();
			issue({OpLlw, 5'(i), 5'd0, r[15:0]});
			issue({OpLhw, 5'(i), 5'd0, r[31:16]});
		end
		for (int n = 0; n < 300; n++) begin
			issueRandom();
			r = nextRand();
			if (r[2:0] == 3'b000)
				idle(1 + int'(r[3]));
		end
		idle(1);
		foreach (badOps[i]) begin
			r = nextRand();
			issue({badOps[i], r[25:0]});
		end
		idle(2);
		issue({OpHalt, 26'd0});
		repeat (10) issueRandom();
		idle(4);
		stimDone <= 1'b1;
		timeout = 0;
		while (!done && timeout < 200) begin
			@(posedge clk);
			timeout++;
		end
		if (!done)
			$display("Timeout: the checker never reported that it was done");
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (done && errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
